//--- msrh_l2_boot.f
+incdir+hw
hw/msrh_l2_pkg.sv
hw/msrh_boot_loader.sv
hw/msrh_l2_ram.sv
hw/msrh_fetch_cfg.sv
hw/msrh_fetch_unit.sv
hw/msrh_l2_top.sv
verif/msrh_l2_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the msrh_l2_boot testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f msrh_l2_boot.f --top-module msrh_l2_tb -Mdir "$OBJ" -o msrh_l2_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/msrh_l2_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
  exit 0
fi
echo "Simulation did not pass, see $LOG"
exit 1

//--- verif/msrh_l2_tb.sv
`timescale 1ns/1ps
`include "msrh_l2_consts.svh"

module msrh_l2_tb;

  localparam int IMG_ROWS    = 16;
  localparam int RUN_ROWS    = 5;
  localparam int CYCLE_LIMIT = 50 * (IMG_ROWS + RUN_ROWS) + 200;

  typedef struct packed {
    logic                         restart;   // Boot mode drops and the image restarts at word 0
    logic [`MSRH_DATA_W-1:0]      data;
    logic [`MSRH_DATA_W/8-1:0]    byte_en;
  } img_row_t;

  typedef struct packed {
    logic [7:0]                   load_upto; // Image rows in memory before the run
    logic [`MSRH_PADDR_W-1:0]     start_pc;
    logic [`MSRH_PADDR_W-1:0]     count;
  } run_row_t;

  localparam img_row_t IMG_TAB [IMG_ROWS] = '{
    '{1'b1, 64'h00a0_0113_0050_0093, 8'hFF},
    '{1'b0, 64'h0020_8233_0011_01b3, 8'hFF},
    '{1'b0, 64'h4020_82b3_0030_f313, 8'hFF},
    '{1'b0, 64'h0042_a023_0010_0393, 8'hFF},
    '{1'b0, 64'hfe00_0ee3_0073_8393, 8'hFF},
    '{1'b0, 64'h0010_0073_0000_006f, 8'hFF},
    '{1'b0, 64'h1234_5678_9abc_def0, 8'hFF},
    '{1'b0, 64'h0fed_cba9_8765_4321, 8'hFF},
    '{1'b0, 64'hdead_beef_cafe_f00d, 8'hFF},
    '{1'b0, 64'h0123_4567_89ab_cdef, 8'hFF},
    '{1'b0, 64'h5a5a_a5a5_3c3c_c3c3, 8'hFF},
    '{1'b0, 64'h8000_0001_7fff_fffe, 8'hFF},
    // Partial rewrites of words 0 to 3
    '{1'b1, 64'h1111_1111_2222_2222, 8'h0F},
    '{1'b0, 64'h3333_3333_4444_4444, 8'hF0},
    '{1'b0, 64'h5555_5555_6666_6666, 8'h3C},
    '{1'b0, 64'h7777_7777_8888_8888, 8'h81}
  };

  localparam run_row_t RUN_TAB [RUN_ROWS] = '{
    '{8'd12, `MSRH_BASE_ADDR,          32'd6},
    '{8'd12, `MSRH_BASE_ADDR,          32'd24},
    '{8'd16, `MSRH_BASE_ADDR,          32'd8},
    '{8'd16, `MSRH_BASE_ADDR + 32'h200, 32'd4},   // Past the end of the window
    '{8'd16, `MSRH_BASE_ADDR + 32'h20,  32'd7}
  };

  logic                         i_clk;
  logic                         i_msrh_reset_n;
  logic                         i_boot_mode;
  logic                         i_img_valid;
  logic [`MSRH_DATA_W-1:0]      i_img_data;
  logic [`MSRH_DATA_W/8-1:0]    i_img_byte_en;
  logic                         i_cfg_we;
  logic                         i_cfg_addr;
  logic [`MSRH_PADDR_W-1:0]     i_cfg_wdata;
  logic                         o_insn_valid;
  logic [`MSRH_DATA_W/2-1:0]    o_insn;
  logic [`MSRH_PADDR_W-1:0]     o_insn_pc;
  logic                         o_fetch_done;

  logic [`MSRH_DATA_W-1:0]      model_mem [`MSRH_RAM_WORDS];
  logic [15:0]                  lfsr_state;
  int                           img_next;
  int                           model_idx;
  int                           value_errs;
  int                           other_errs;
  int                           cycle_cnt = 0;

  msrh_l2_top dut (.*);

  always #10 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [`MSRH_DATA_W/2-1:0] expected_insn(
      input logic [`MSRH_PADDR_W-1:0] pc);
    logic [`MSRH_PADDR_W-1:0] off;
    logic [`MSRH_DATA_W-1:0]  word;
    off = pc - `MSRH_BASE_ADDR;
    if (off >= `MSRH_PADDR_W'(`MSRH_RAM_WORDS * 8)) begin
      return '0;   // Outside the memory reads as zero
    end
    word = model_mem[int'(off >> 3)];
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

  task automatic next_cycle();
    @(negedge i_clk);
  endtask

  task automatic check_insn(input logic [`MSRH_DATA_W/2-1:0] exp_insn,
                            input logic [`MSRH_PADDR_W-1:0] exp_pc);
    if (o_insn !== exp_insn) begin
      value_errs++;
      $display("ERROR t=%0t o_insn exp=%08h act=%08h", $time, exp_insn, o_insn);
    end
    if (o_insn_pc !== exp_pc) begin
      value_errs++;
      $display("ERROR t=%0t o_insn_pc exp=%08h act=%08h", $time, exp_pc, o_insn_pc);
    end
  endtask

  task automatic check_done(input logic exp_done);
    if (o_fetch_done !== exp_done) begin
      value_errs++;
      $display("ERROR t=%0t o_fetch_done exp=%0b act=%0b", $time, exp_done, o_fetch_done);
    end
  endtask

  task automatic load_image(input int upto);
    int gap;
    if (img_next < upto) begin
      i_boot_mode = 1'b1;
      while (img_next < upto) begin
        if (IMG_TAB[img_next].restart) begin
          i_boot_mode = 1'b0;
          next_cycle();
          i_boot_mode = 1'b1;
          next_cycle();
          model_idx = 0;
        end
        i_img_valid   = 1'b1;
        i_img_data    = IMG_TAB[img_next].data;
        i_img_byte_en = IMG_TAB[img_next].byte_en;
        for (int b = 0; b < `MSRH_DATA_W / 8; b++) begin
          if (IMG_TAB[img_next].byte_en[b]) begin
            model_mem[model_idx][b*8 +: 8] = IMG_TAB[img_next].data[b*8 +: 8];
          end
        end
        next_cycle();
        i_img_valid = 1'b0;
        lfsr_state  = lfsr_next(lfsr_state);
        gap         = 1 + int'(lfsr_state[0]);   // Strobes 2 or 3 cycles apart
        repeat (gap) next_cycle();
        model_idx++;
        img_next++;
      end
      repeat (2) next_cycle();   // Let the last pending write drain
      i_boot_mode = 1'b0;
      next_cycle();
    end
  endtask

  task automatic write_cfg(input logic addr, input logic [`MSRH_PADDR_W-1:0] data);
    i_cfg_we    = 1'b1;
    i_cfg_addr  = addr;
    i_cfg_wdata = data;
    next_cycle();
    i_cfg_we    = 1'b0;
  endtask

  task automatic run_fetch(input run_row_t row);
    logic [`MSRH_PADDR_W-1:0] pc;
    int                       got;
    load_image(int'(row.load_upto));
    write_cfg(1'b0, row.start_pc);
    write_cfg(1'b1, row.count);
    pc  = row.start_pc;
    got = 0;
    while (got < int'(row.count)) begin
      next_cycle();
      if (o_insn_valid) begin
        check_done(1'b0);
        check_insn(expected_insn(pc), pc);
        pc = pc + `MSRH_PADDR_W'(4);
        got++;
      end
    end
    next_cycle();
    while (!o_fetch_done) next_cycle();
    repeat (2 * `MSRH_RD_LAT) begin
      if (o_insn_valid) begin
        other_errs++;
        $display("Extra instruction at pc %08h after the run of %0d ended", o_insn_pc,
                 row.count);
      end
      check_done(1'b1);
      next_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    i_clk          = 1'b0;
    i_msrh_reset_n = 1'b0;
    i_boot_mode    = 1'b0;
    i_img_valid    = 1'b0;
    i_img_data     = '0;
    i_img_byte_en  = '0;
    i_cfg_we       = 1'b0;
    i_cfg_addr     = 1'b0;
    i_cfg_wdata    = '0;
    lfsr_state     = 16'h0001;
    img_next       = 0;
    model_idx      = 0;
    value_errs     = 0;
    other_errs     = 0;
    for (int i = 0; i < `MSRH_RAM_WORDS; i++) model_mem[i] = '0;

    repeat (4) next_cycle();
    i_msrh_reset_n = 1'b1;

    // Idle with no configuration
    repeat (10) begin
      next_cycle();
      if (o_insn_valid) begin
        other_errs++;
        $display("Instruction strobe seen before any run was configured");
      end
      check_done(1'b0);
    end

    for (int r = 0; r < RUN_ROWS; r++) run_fetch(RUN_TAB[r]);

    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- hw/msrh_l2_top.sv
`timescale 1ns/1ps
`include "msrh_l2_consts.svh"

module msrh_l2_top (
  input  logic                         i_clk,
  input  logic                         i_msrh_reset_n,
  input  logic                         i_boot_mode,

  input  logic                         i_img_valid,
  input  logic [`MSRH_DATA_W-1:0]      i_img_data,
  input  logic [`MSRH_DATA_W/8-1:0]    i_img_byte_en,

  input  logic                         i_cfg_we,
  input  logic                         i_cfg_addr,
  input  logic [`MSRH_PADDR_W-1:0]     i_cfg_wdata,

  output logic                         o_insn_valid,
  output logic [`MSRH_DATA_W/2-1:0]    o_insn,
  output logic [`MSRH_PADDR_W-1:0]     o_insn_pc,
  output logic                         o_fetch_done
);

  ////////////////////////////////////////////////////////////////////////////
  // Fetch request into the loader select
  logic                         w_fr_valid;
  msrh_l2_pkg::mem_cmd_t        w_fr_cmd;
  logic [`MSRH_PADDR_W-1:0]     w_fr_addr;
  logic [`MSRH_TAG_W-1:0]       w_fr_tag;
  logic [`MSRH_DATA_W-1:0]      w_fr_data;
  logic [`MSRH_DATA_W/8-1:0]    w_fr_byte_en;
  logic                         w_fr_ready;

  // L2 request and response
  logic                         w_req_valid;
  msrh_l2_pkg::mem_cmd_t        w_req_cmd;
  logic [`MSRH_PADDR_W-1:0]     w_req_addr;
  logic [`MSRH_TAG_W-1:0]       w_req_tag;
  logic [`MSRH_DATA_W-1:0]      w_req_data;
  logic [`MSRH_DATA_W/8-1:0]    w_req_byte_en;
  logic                         w_req_ready;
  logic                         w_resp_valid;
  logic [`MSRH_TAG_W-1:0]       w_resp_tag;
  logic [`MSRH_DATA_W-1:0]      w_resp_data;
  logic                         w_resp_ready;

  logic [`MSRH_PADDR_W-1:0]     w_start_pc;
  logic [`MSRH_PADDR_W-1:0]     w_count;
  logic                         w_start;

  msrh_boot_loader u_boot_loader (
    .i_clk          (i_clk),
    .i_msrh_reset_n (i_msrh_reset_n),
    .i_boot_mode    (i_boot_mode),
    .i_img_valid    (i_img_valid),
    .i_img_data     (i_img_data),
    .i_img_byte_en  (i_img_byte_en),
    .i_fr_valid     (w_fr_valid),
    .i_fr_cmd       (w_fr_cmd),
    .i_fr_addr      (w_fr_addr),
    .i_fr_tag       (w_fr_tag),
    .i_fr_data      (w_fr_data),
    .i_fr_byte_en   (w_fr_byte_en),
    .o_fr_ready     (w_fr_ready),
    .o_req_valid    (w_req_valid),
    .o_req_cmd      (w_req_cmd),
    .o_req_addr     (w_req_addr),
    .o_req_tag      (w_req_tag),
    .o_req_data     (w_req_data),
    .o_req_byte_en  (w_req_byte_en),
    .i_req_ready    (w_req_ready)
  );

  msrh_l2_ram u_l2_ram (
    .i_clk          (i_clk),
    .i_msrh_reset_n (i_msrh_reset_n),
    .i_req_valid    (w_req_valid),
    .i_req_cmd      (w_req_cmd),
    .i_req_addr     (w_req_addr),
    .i_req_tag      (w_req_tag),
    .i_req_data     (w_req_data),
    .i_req_byte_en  (w_req_byte_en),
    .o_req_ready    (w_req_ready),
    .o_resp_valid   (w_resp_valid),
    .o_resp_tag     (w_resp_tag),
    .o_resp_data    (w_resp_data),
    .i_resp_ready   (w_resp_ready)
  );

  msrh_fetch_cfg u_fetch_cfg (
    .i_clk          (i_clk),
    .i_msrh_reset_n (i_msrh_reset_n),
    .i_cfg_we       (i_cfg_we),
    .i_cfg_addr     (i_cfg_addr),
    .i_cfg_wdata    (i_cfg_wdata),
    .o_start_pc     (w_start_pc),
    .o_count        (w_count),
    .o_start        (w_start)
  );

  msrh_fetch_unit u_fetch_unit (
    .i_clk          (i_clk),
    .i_msrh_reset_n (i_msrh_reset_n),
    .i_start        (w_start),
    .i_start_pc     (w_start_pc),
    .i_count        (w_count),
    .o_fr_valid     (w_fr_valid),
    .o_fr_cmd       (w_fr_cmd),
    .o_fr_addr      (w_fr_addr),
    .o_fr_tag       (w_fr_tag),
    .o_fr_data      (w_fr_data),
    .o_fr_byte_en   (w_fr_byte_en),
    .i_fr_ready     (w_fr_ready),
    .i_resp_valid   (w_resp_valid),
    .i_resp_tag     (w_resp_tag),
    .i_resp_data    (w_resp_data),
    .o_resp_ready   (w_resp_ready),
    .o_insn_valid   (o_insn_valid),
    .o_insn         (o_insn),
    .o_insn_pc      (o_insn_pc),
    .o_fetch_done   (o_fetch_done)
  );

endmodule

//--- hw/msrh_fetch_unit.sv
`timescale 1ns/1ps
`include "msrh_l2_consts.svh"

module msrh_fetch_unit (
  input  logic                         i_clk,
  input  logic                         i_msrh_reset_n,

  input  logic                         i_start,
  input  logic [`MSRH_PADDR_W-1:0]     i_start_pc,
  input  logic [`MSRH_PADDR_W-1:0]     i_count,

  output logic                         o_fr_valid,
  output msrh_l2_pkg::mem_cmd_t        o_fr_cmd,
  output logic [`MSRH_PADDR_W-1:0]     o_fr_addr,
  output logic [`MSRH_TAG_W-1:0]       o_fr_tag,
  output logic [`MSRH_DATA_W-1:0]      o_fr_data,
  output logic [`MSRH_DATA_W/8-1:0]    o_fr_byte_en,
  input  logic                         i_fr_ready,

  input  logic                         i_resp_valid,
  input  logic [`MSRH_TAG_W-1:0]       i_resp_tag,
  input  logic [`MSRH_DATA_W-1:0]      i_resp_data,
  output logic                         o_resp_ready,

  output logic                         o_insn_valid,
  output logic [`MSRH_DATA_W/2-1:0]    o_insn,
  output logic [`MSRH_PADDR_W-1:0]     o_insn_pc,
  output logic                         o_fetch_done
);

  localparam int OUT_W  = $clog2(`MSRH_FETCH_MAX_OUT + 1);
  localparam int INSN_W = `MSRH_DATA_W / 2;

  logic [`MSRH_PADDR_W-1:0]   r_fetch_addr;
  logic [`MSRH_PADDR_W-1:0]   r_resp_pc;
  logic [`MSRH_PADDR_W-1:0]   r_words_left;
  logic [`MSRH_PADDR_W-1:0]   r_insn_left;
  logic [`MSRH_TAG_W-1:0]     r_tag;
  logic [`MSRH_TAG_W-1:0]     r_exp_tag;
  logic [OUT_W-1:0]           r_outstanding;
  logic                       r_half;         // Upper instruction still to go out
  logic                       r_done;
  logic [INSN_W-1:0]          r_hi_insn;
  logic [`MSRH_PADDR_W-1:0]   r_hi_pc;

  msrh_l2_pkg::fetch_word_u   w_word;
  logic [`MSRH_PADDR_W:0]     w_count_p1;
  logic [`MSRH_PADDR_W-1:0]   w_start_base;
  logic                       w_issue;
  logic                       w_resp;
  logic                       w_emit;

  assign w_word       = i_resp_data;
  assign w_count_p1   = {1'b0, i_count} + 1'b1;
  assign w_start_base = {i_start_pc[`MSRH_PADDR_W-1:3], 3'b000};

  assign o_fr_valid   = (r_words_left != '0) &&
                        (r_outstanding < OUT_W'(`MSRH_FETCH_MAX_OUT));
  assign o_fr_cmd     = msrh_l2_pkg::CMD_RD;
  assign o_fr_addr    = r_fetch_addr;
  assign o_fr_tag     = r_tag;
  assign o_fr_data    = '0;
  assign o_fr_byte_en = '1;

  assign w_issue      = o_fr_valid & i_fr_ready;
  assign o_resp_ready = ~r_half;
  assign w_resp       = i_resp_valid & ~r_half;
  assign w_emit       = w_resp | r_half;

  assign o_insn_valid = w_emit;
  assign o_insn       = r_half ? r_hi_insn : w_word.insn[0];
  assign o_insn_pc    = r_half ? r_hi_pc   : r_resp_pc;
  assign o_fetch_done = r_done;

  always_ff @(posedge i_clk) begin
    if (!i_msrh_reset_n) begin
      r_words_left  <= '0;
      r_insn_left   <= '0;
      r_tag         <= '0;
      r_exp_tag     <= '0;
      r_outstanding <= '0;
      r_half        <= 1'b0;
      r_done        <= 1'b0;
    end else begin
      r_outstanding <= r_outstanding + OUT_W'(w_issue) - OUT_W'(w_resp);
      if (w_issue) r_tag <= r_tag + 1'b1;
      if (w_resp)  r_exp_tag <= r_exp_tag + 1'b1;
      r_half <= w_resp && (r_insn_left > `MSRH_PADDR_W'(1));  // Odd tail drops upper half
      if (i_start) begin
        r_words_left <= w_count_p1[`MSRH_PADDR_W:1];
        r_insn_left  <= i_count;
        r_done       <= (i_count == '0);
      end else begin
        if (w_issue) r_words_left <= r_words_left - 1'b1;
        if (w_emit)  r_insn_left  <= r_insn_left - 1'b1;
        if (w_emit && r_insn_left == `MSRH_PADDR_W'(1)) r_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      r_fetch_addr <= w_start_base;
      r_resp_pc    <= w_start_base;
    end else begin
      if (w_issue) r_fetch_addr <= r_fetch_addr + `MSRH_PADDR_W'(8);
      if (w_resp)  r_resp_pc    <= r_resp_pc + `MSRH_PADDR_W'(8);
    end
    if (w_resp) begin
      r_hi_insn <= w_word.insn[1];
      r_hi_pc   <= r_resp_pc + `MSRH_PADDR_W'(4);
    end
  end

  // Memory returns reads in issue order
  a_resp_in_order: assert property (@(posedge i_clk) disable iff (!i_msrh_reset_n)
    w_resp |-> i_resp_tag == r_exp_tag);

endmodule

//--- hw/msrh_fetch_cfg.sv
`timescale 1ns/1ps
`include "msrh_l2_consts.svh"

module msrh_fetch_cfg (
  input  logic                       i_clk,
  input  logic                       i_msrh_reset_n,

  input  logic                       i_cfg_we,
  input  logic                       i_cfg_addr,     // 0 start address, 1 count
  input  logic [`MSRH_PADDR_W-1:0]   i_cfg_wdata,

  output logic [`MSRH_PADDR_W-1:0]   o_start_pc,
  output logic [`MSRH_PADDR_W-1:0]   o_count,
  output logic                       o_start
);

  logic [`MSRH_PADDR_W-1:0]   r_start_pc;
  logic [`MSRH_PADDR_W-1:0]   r_count;
  logic                       r_start;

  always_ff @(posedge i_clk) begin
    if (!i_msrh_reset_n) begin
      r_start_pc <= '0;
      r_count    <= '0;
      r_start    <= 1'b0;
    end else begin
      r_start <= i_cfg_we & i_cfg_addr;  // Count write launches a run
      if (i_cfg_we && !i_cfg_addr) begin
        r_start_pc <= i_cfg_wdata;
      end
      if (i_cfg_we && i_cfg_addr) begin
        r_count <= i_cfg_wdata;
      end
    end
  end

  assign o_start_pc = r_start_pc;
  assign o_count    = r_count;
  assign o_start    = r_start;

endmodule

//--- hw/msrh_l2_ram.sv
`timescale 1ns/1ps
`include "msrh_l2_consts.svh"

module msrh_l2_ram (
  input  logic                         i_clk,
  input  logic                         i_msrh_reset_n,

  input  logic                         i_req_valid,
  input  msrh_l2_pkg::mem_cmd_t        i_req_cmd,
  input  logic [`MSRH_PADDR_W-1:0]     i_req_addr,
  input  logic [`MSRH_TAG_W-1:0]       i_req_tag,
  input  logic [`MSRH_DATA_W-1:0]      i_req_data,
  input  logic [`MSRH_DATA_W/8-1:0]    i_req_byte_en,
  output logic                         o_req_ready,

  output logic                         o_resp_valid,
  output logic [`MSRH_TAG_W-1:0]       o_resp_tag,
  output logic [`MSRH_DATA_W-1:0]      o_resp_data,
  input  logic                         i_resp_ready
);

  localparam int IDX_W  = $clog2(`MSRH_RAM_WORDS);
  localparam int BYTES  = `MSRH_DATA_W / 8;
  localparam int LAT    = `MSRH_RD_LAT;

  msrh_l2_pkg::fetch_word_u     r_mem [`MSRH_RAM_WORDS];

  logic [`MSRH_PADDR_W-1:0]     w_offset;
  logic                         w_in_range;
  logic [IDX_W-1:0]             w_idx;
  logic                         w_acc;
  logic                         w_wr_acc;
  logic                         w_rd_acc;
  logic                         w_stall;

  logic [LAT-1:0]               r_pipe_valid;
  logic [`MSRH_TAG_W-1:0]       r_pipe_tag  [LAT];
  msrh_l2_pkg::fetch_word_u     r_pipe_data [LAT];

  // Addresses below the base wrap high and fall out of range
  assign w_offset   = i_req_addr - `MSRH_BASE_ADDR;
  assign w_in_range = w_offset < `MSRH_PADDR_W'(`MSRH_RAM_WORDS * BYTES);
  assign w_idx      = w_offset[IDX_W+2:3];

  assign w_stall     = r_pipe_valid[LAT-1] & ~i_resp_ready;  // Held response freezes all stages
  assign o_req_ready = ~w_stall;

  assign w_acc    = i_req_valid & o_req_ready;
  assign w_wr_acc = w_acc & (i_req_cmd == msrh_l2_pkg::CMD_WR);
  assign w_rd_acc = w_acc & (i_req_cmd == msrh_l2_pkg::CMD_RD);

  ////////////////////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge i_clk) begin
    if (w_wr_acc && w_in_range) begin
      for (int b = 0; b < BYTES; b++) begin
        if (i_req_byte_en[b]) begin
          r_mem[w_idx].raw[b*8 +: 8] <= i_req_data[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read latency pipeline

  always_ff @(posedge i_clk) begin
    if (!i_msrh_reset_n) begin
      r_pipe_valid <= '0;
    end else if (!w_stall) begin
      r_pipe_valid <= {r_pipe_valid[LAT-2:0], w_rd_acc};
    end
  end

  always_ff @(posedge i_clk) begin
    if (!w_stall) begin
      r_pipe_tag[0] <= i_req_tag;
      if (w_in_range) begin
        r_pipe_data[0] <= r_mem[w_idx];
      end else begin
        r_pipe_data[0] <= '0;
      end
      for (int s = 1; s < LAT; s++) begin
        r_pipe_tag[s]  <= r_pipe_tag[s-1];
        r_pipe_data[s] <= r_pipe_data[s-1];
      end
    end
  end

  assign o_resp_valid = r_pipe_valid[LAT-1];
  assign o_resp_tag   = r_pipe_tag[LAT-1];
  assign o_resp_data  = r_pipe_data[LAT-1].raw;

  a_resp_hold: assert property (@(posedge i_clk) disable iff (!i_msrh_reset_n)
    o_resp_valid && !i_resp_ready |=>
      o_resp_valid && $stable(o_resp_tag) && $stable(o_resp_data));

endmodule

//--- hw/msrh_boot_loader.sv
`timescale 1ns/1ps
`include "msrh_l2_consts.svh"

module msrh_boot_loader (
  input  logic                         i_clk,
  input  logic                         i_msrh_reset_n,
  input  logic                         i_boot_mode,

  input  logic                         i_img_valid,
  input  logic [`MSRH_DATA_W-1:0]      i_img_data,
  input  logic [`MSRH_DATA_W/8-1:0]    i_img_byte_en,

  input  logic                         i_fr_valid,
  input  msrh_l2_pkg::mem_cmd_t        i_fr_cmd,
  input  logic [`MSRH_PADDR_W-1:0]     i_fr_addr,
  input  logic [`MSRH_TAG_W-1:0]       i_fr_tag,
  input  logic [`MSRH_DATA_W-1:0]      i_fr_data,
  input  logic [`MSRH_DATA_W/8-1:0]    i_fr_byte_en,
  output logic                         o_fr_ready,

  output logic                         o_req_valid,
  output msrh_l2_pkg::mem_cmd_t        o_req_cmd,
  output logic [`MSRH_PADDR_W-1:0]     o_req_addr,
  output logic [`MSRH_TAG_W-1:0]       o_req_tag,
  output logic [`MSRH_DATA_W-1:0]      o_req_data,
  output logic [`MSRH_DATA_W/8-1:0]    o_req_byte_en,
  input  logic                         i_req_ready
);

  logic                         r_boot_d;
  logic                         w_boot_rise;
  logic [`MSRH_PADDR_W-1:0]     r_img_addr;
  logic [`MSRH_PADDR_W-1:0]     w_img_addr;
  logic                         w_img_wr;
  logic                         w_pend_acc;

  logic                         r_pend_valid;
  logic [`MSRH_PADDR_W-1:0]     r_pend_addr;
  logic [`MSRH_DATA_W-1:0]      r_pend_data;
  logic [`MSRH_DATA_W/8-1:0]    r_pend_byte_en;

  assign w_boot_rise = i_boot_mode & ~r_boot_d;
  assign w_img_addr  = w_boot_rise ? `MSRH_BASE_ADDR : r_img_addr;  // Restart image at word 0
  assign w_img_wr    = i_boot_mode & i_img_valid;
  assign w_pend_acc  = i_boot_mode & r_pend_valid & i_req_ready;

  always_ff @(posedge i_clk) begin
    if (!i_msrh_reset_n) begin
      r_boot_d     <= 1'b0;
      r_img_addr   <= `MSRH_BASE_ADDR;
      r_pend_valid <= 1'b0;
    end else begin
      r_boot_d <= i_boot_mode;
      if (w_img_wr) begin
        r_img_addr <= w_img_addr + `MSRH_PADDR_W'(`MSRH_DATA_W / 8);
      end else begin
        r_img_addr <= w_img_addr;
      end
      if (w_img_wr) begin
        r_pend_valid <= 1'b1;
      end else if (w_pend_acc) begin
        r_pend_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_img_wr) begin
      r_pend_addr    <= w_img_addr;
      r_pend_data    <= i_img_data;
      r_pend_byte_en <= i_img_byte_en;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request select

  assign o_req_valid   = i_boot_mode ? r_pend_valid           : i_fr_valid;
  assign o_req_cmd     = i_boot_mode ? msrh_l2_pkg::CMD_WR    : i_fr_cmd;
  assign o_req_addr    = i_boot_mode ? r_pend_addr            : i_fr_addr;
  assign o_req_tag     = i_boot_mode ? '0                     : i_fr_tag;
  assign o_req_data    = i_boot_mode ? r_pend_data            : i_fr_data;
  assign o_req_byte_en = i_boot_mode ? r_pend_byte_en         : i_fr_byte_en;
  assign o_fr_ready    = ~i_boot_mode & i_req_ready;

  // Fetch must stay idle until the image is in place
  a_no_fetch_in_boot: assert property (@(posedge i_clk) disable iff (!i_msrh_reset_n)
    i_boot_mode |-> !i_fr_valid);

endmodule

//--- hw/msrh_l2_pkg.sv
`include "msrh_l2_consts.svh"

package msrh_l2_pkg;

  typedef enum logic {
    CMD_RD = 1'b0,
    CMD_WR = 1'b1
  } mem_cmd_t;

  // Raw memory word or two instructions with the lower address in insn[0]
  typedef union packed {
    logic [`MSRH_DATA_W-1:0]          raw;
    logic [1:0][`MSRH_DATA_W/2-1:0]   insn;
  } fetch_word_u;

endpackage

//--- hw/msrh_l2_consts.svh
`ifndef MSRH_L2_CONSTS_SVH
`define MSRH_L2_CONSTS_SVH

`define MSRH_PADDR_W        32
`define MSRH_DATA_W         64
`define MSRH_TAG_W          3

// Memory window
`define MSRH_RAM_WORDS      64
`define MSRH_BASE_ADDR      32'h8000_0000
`define MSRH_RD_LAT         4

`define MSRH_FETCH_MAX_OUT  4   // Reads in flight from fetch

`endif
